// File: mipsDecodeStage.f
rtl/mipsPkg.sv
rtl/instrReceiver.sv
rtl/categoryDecoder.sv
rtl/regControlGenerate.sv
rtl/registerFile.sv
rtl/operandSender.sv
rtl/mipsDecodeStage.sv
tests/mipsDecodeStageTb.sv

// File: run.sh
#!/bin/bash
# build with Verilator and run; the exit status follows the testbench result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module mipsDecodeStageTb \
	-f mipsDecodeStage.f -o mipsDecodeStageSim &&
./obj_dir/mipsDecodeStageSim | tee /dev/stderr | grep "Simulation PASSED" > /dev/null &&
echo "run.sh: simulation ok" || { echo "run.sh: simulation did not pass"; exit 1; }

// File: tests/mipsDecodeStageTb.sv
`timescale 1ns/1ps

module mipsDecodeStageTb;

	import mipsPkg::*;

	localparam int ResetCycles = 16;
	localparam int MaxOps = 64;
	// instructions plus writeback strobes over all tests, rounded up
	localparam int TransactionCount = 72;
	localparam int WatchdogCycles = TransactionCount * 40 + ResetCycles;
	localparam int BundleWidth = 3 * DataWidth + RegAddrWidth + $bits(writeDataSrc_e) + 1
		+ $bits(category_e) + ImmWidth + ShamtWidth;
	localparam logic [31:0] Seed = 32'h5416_5a9e;

	logic clk;
	logic reset;
	logic instrReq;
	logic [DataWidth-1:0] instr;
	logic [DataWidth-1:0] pc;
	logic wbEnable;
	logic [RegAddrWidth-1:0] wbAddr;
	logic [DataWidth-1:0] wbData;
	logic opAck;
	logic instrAck;
	logic opReq;
	logic [DataWidth-1:0] port1Data;
	logic [DataWidth-1:0] port2Data;
	logic [RegAddrWidth-1:0] writeAddr;
	writeDataSrc_e writeDataSrc;
	logic writeEnable;
	category_e category;
	logic [ImmWidth-1:0] imm;
	logic [ShamtWidth-1:0] shamt;
	logic [DataWidth-1:0] pcOut;
	logic [BundleWidth-1:0] bundle;

	// reference model state
	logic [DataWidth-1:0] shadow [32];
	logic [DataWidth-1:0] expPort1 [MaxOps];
	logic [DataWidth-1:0] expPort2 [MaxOps];
	logic [RegAddrWidth-1:0] expWriteAddr [MaxOps];
	writeDataSrc_e expWriteDataSrc [MaxOps];
	logic expWriteEnable [MaxOps];
	category_e expCategory [MaxOps];
	logic [ImmWidth-1:0] expImm [MaxOps];
	logic [ShamtWidth-1:0] expShamt [MaxOps];
	logic [DataWidth-1:0] expPc [MaxOps];

	int expCount;
	int opIndex;
	int errorCount;
	int testErrorsAtStart;
	int testCount;
	int failedTests;
	string testName;

	mipsDecodeStage #(
		.RegCount(32)
	) mipsDecodeStage_inst (
		.clk(clk),
		.reset(reset),
		.instrReq(instrReq),
		.instr(instr),
		.pc(pc),
		.wbEnable(wbEnable),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.opAck(opAck),
		.instrAck(instrAck),
		.opReq(opReq),
		.port1Data(port1Data),
		.port2Data(port2Data),
		.writeAddr(writeAddr),
		.writeDataSrc(writeDataSrc),
		.writeEnable(writeEnable),
		.category(category),
		.imm(imm),
		.shamt(shamt),
		.pcOut(pcOut)
	);

	assign bundle = {port1Data, port2Data, writeAddr, writeDataSrc, writeEnable, category,
		imm, shamt, pcOut};

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function void reportValue(input string field, input logic [31:0] expected,
			input logic [31:0] actual);
		errorCount++;
		$display("Fail %s %s: expected %h actual %h", testName, field, expected, actual);
	endfunction

	function void reportProtocol(input string what);
		errorCount++;
		$display("protocol error in %s: %s", testName, what);
	endfunction

	// bundle fields against the model, sampled at the edge after opReq rises
	checkPort1: assert property (@(posedge clk) disable iff (reset)
		$rose(opReq) |-> port1Data == expPort1[opIndex])
		else reportValue("port1Data", expPort1[opIndex], port1Data);
	checkPort2: assert property (@(posedge clk) disable iff (reset)
		$rose(opReq) |-> port2Data == expPort2[opIndex])
		else reportValue("port2Data", expPort2[opIndex], port2Data);
	checkWriteAddr: assert property (@(posedge clk) disable iff (reset)
		$rose(opReq) |-> writeAddr == expWriteAddr[opIndex])
		else reportValue("writeAddr", 32'(expWriteAddr[opIndex]), 32'(writeAddr));
	checkWriteDataSrc: assert property (@(posedge clk) disable iff (reset)
		$rose(opReq) |-> writeDataSrc == expWriteDataSrc[opIndex])
		else reportValue("writeDataSrc", 32'(expWriteDataSrc[opIndex]), 32'(writeDataSrc));
	checkWriteEnable: assert property (@(posedge clk) disable iff (reset)
		$rose(opReq) |-> writeEnable == expWriteEnable[opIndex])
		else reportValue("writeEnable", 32'(expWriteEnable[opIndex]), 32'(writeEnable));
	checkCategory: assert property (@(posedge clk) disable iff (reset)
		$rose(opReq) |-> category == expCategory[opIndex])
		else reportValue("category", 32'(expCategory[opIndex]), 32'(category));
	checkImm: assert property (@(posedge clk) disable iff (reset)
		$rose(opReq) |-> imm == expImm[opIndex])
		else reportValue("imm", 32'(expImm[opIndex]), 32'(imm));
	checkShamt: assert property (@(posedge clk) disable iff (reset)
		$rose(opReq) |-> shamt == expShamt[opIndex])
		else reportValue("shamt", 32'(expShamt[opIndex]), 32'(shamt));
	checkPc: assert property (@(posedge clk) disable iff (reset)
		$rose(opReq) |-> pcOut == expPc[opIndex])
		else reportValue("pcOut", expPc[opIndex], pcOut);

	// acceptance edge is three edges before the one that first sees opReq high
	checkLatency: assert property (@(posedge clk) disable iff (reset)
		$rose(opReq) |-> ($past(instrAck, 2) && !$past(instrAck, 3)))
		else reportProtocol("opReq did not rise two cycles after the accepting edge");
	checkNoAccept: assert property (@(posedge clk) disable iff (reset)
		opReq |=> !$rose(instrAck))
		else reportProtocol("a new instruction was acknowledged while opReq was pending");
	checkStable: assert property (@(posedge clk) disable iff (reset)
		(opReq && $past(opReq)) |-> $stable(bundle))
		else reportProtocol("the operand bundle changed while opReq was held");

	function automatic category_e expectCategory(input logic [31:0] word);
		logic [5:0] op;
		logic [5:0] fn;
		logic [4:0] rtField;
		op = word[31:26];
		fn = word[5:0];
		rtField = word[20:16];
		if (op == 6'd0) begin
			if (fn == 6'd8) return catJump;
			if (fn == 6'd9) return catLink;
			// sll srl sra sllv srlv srav
			if (fn <= 6'd7 && fn != 6'd1 && fn != 6'd5) return catShift;
			return catRegister;
		end
		if (op == 6'd1) return (rtField == 5'd16 || rtField == 5'd17) ? catLink : catBranch;
		if (op == 6'd2) return catJump;
		if (op == 6'd3) return catLink;
		if (op >= 6'd4 && op <= 6'd7) return catBranch;
		if (op >= 6'd8 && op <= 6'd15) return catImmediate;
		if (op inside {6'd32, 6'd33, 6'd35, 6'd36, 6'd37}) return catLoad;
		if (op inside {6'd40, 6'd41, 6'd43}) return catStore;
		return catInvalid;
	endfunction

	function automatic logic [31:0] randomWord(input logic [5:0] op);
		logic [31:0] w;
		w = $urandom();
		w[31:26] = op;
		return w;
	endfunction

	function automatic logic [31:0] specialWord(input logic [5:0] fn);
		logic [31:0] w;
		w = randomWord(6'd0);
		w[5:0] = fn;
		return w;
	endfunction

	function automatic logic [31:0] regimmWord(input logic [4:0] rtField);
		logic [31:0] w;
		w = randomWord(6'd1);
		w[20:16] = rtField;
		return w;
	endfunction

	task automatic pushExpected(input logic [31:0] word, input logic [31:0] pcVal);
		category_e cat;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		cat = expectCategory(word);
		rs = word[25:21];
		rt = word[20:16];
		rd = word[15:11];
		expCategory[expCount] = cat;
		expPort1[expCount] = (cat == catShift) ? shadow[rt] : shadow[rs];
		expPort2[expCount] = (cat == catShift) ? shadow[rs] : shadow[rt];
		if (cat == catLink) begin
			expWriteAddr[expCount] = 5'd31;
		end else if (cat == catShift || cat == catRegister) begin
			expWriteAddr[expCount] = rd;
		end else begin
			expWriteAddr[expCount] = rt;
		end
		if (cat == catLoad) begin
			expWriteDataSrc[expCount] = wdMemory;
		end else if (cat == catLink) begin
			expWriteDataSrc[expCount] = wdPc;
		end else begin
			expWriteDataSrc[expCount] = wdAlu;
		end
		expWriteEnable[expCount] = !(cat inside {catJump, catBranch, catStore, catInvalid});
		expImm[expCount] = word[15:0];
		expShamt[expCount] = word[10:6];
		expPc[expCount] = pcVal;
		expCount++;
	endtask

	task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
		wbEnable = 1'b1;
		wbAddr = addr;
		wbData = data;
		@(posedge clk);
		#1;
		wbEnable = 1'b0;
		if (addr != 5'd0) begin
			shadow[addr] = data;
		end
	endtask

	// four-phase source, with an optional writeback at the register read edge
	task automatic sendInstr(input logic [31:0] word, input logic [31:0] pcVal,
			input logic wbOn, input logic [4:0] wbA, input logic [31:0] wbD);
		instr = word;
		pc = pcVal;
		instrReq = 1'b1;
		do begin
			@(posedge clk);
			#1;
		end while (!instrAck);
		instrReq = 1'b0;
		if (wbOn) begin
			wbEnable = 1'b1;
			wbAddr = wbA;
			wbData = wbD;
		end
		@(posedge clk);
		#1;
		wbEnable = 1'b0;
		while (instrAck) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic answerOp(input int delay);
		while (!opReq) begin
			@(posedge clk);
			#1;
		end
		repeat (delay) begin
			@(posedge clk);
			#1;
		end
		opAck = 1'b1;
		while (opReq) begin
			@(posedge clk);
			#1;
		end
		opIndex++;
		opAck = 1'b0;
	endtask

	task automatic runOne(input logic [31:0] word, input int delay, input logic wbOn,
			input logic [4:0] wbA, input logic [31:0] wbD);
		logic [31:0] pcVal;
		pcVal = $urandom();
		pcVal[1:0] = 2'b00;
		// the read sees the strobe, so the model takes it first
		if (wbOn && wbA != 5'd0) begin
			shadow[wbA] = wbD;
		end
		pushExpected(word, pcVal);
		fork
			sendInstr(word, pcVal, wbOn, wbA, wbD);
			answerOp(delay);
		join
	endtask

	task automatic openTest(input string name);
		testName = name;
		testErrorsAtStart = errorCount;
	endtask

	task automatic closeTest();
		testCount++;
		if (errorCount == testErrorsAtStart) begin
			$display("test %s: ok", testName);
		end else begin
			failedTests++;
			$display("test %s: %0d errors", testName, errorCount - testErrorsAtStart);
		end
	endtask

	task automatic writebackRead();
		logic [31:0] word;
		openTest("writebackRead");
		for (int r = 1; r < 32; r++) begin
			writeReg(5'(r), $urandom());
		end
		writeReg(5'd0, $urandom());
		for (int i = 0; i < 10; i++) begin
			word = specialWord(6'h20 + 6'($urandom_range(11, 0)));
			runOne(word, int'($urandom_range(5, 0)), 1'b0, 5'd0, '0);
		end
		word = specialWord(6'h20);
		word[25:16] = 10'd0;
		runOne(word, 1, 1'b0, 5'd0, '0);
		closeTest();
	endtask

	task automatic categoryRules();
		logic [31:0] words [13];
		openTest("categoryRules");
		words[0] = specialWord(6'h21);
		words[1] = specialWord(6'd2);
		words[2] = randomWord(6'd35);
		words[3] = randomWord(6'd43);
		words[4] = randomWord(6'd4);
		words[5] = randomWord(6'd2);
		words[6] = specialWord(6'd8);
		words[7] = randomWord(6'd3);
		words[8] = specialWord(6'd9);
		// bltzal and bgez
		words[9] = regimmWord(5'd16);
		words[10] = regimmWord(5'd1);
		words[11] = randomWord(6'd13);
		words[12] = randomWord(6'd16 + 6'($urandom_range(15, 0)));
		foreach (words[i]) begin
			runOne(words[i], int'($urandom_range(5, 0)), 1'b0, 5'd0, '0);
		end
		closeTest();
	endtask

	task automatic shiftSwap();
		openTest("shiftSwap");
		for (int i = 0; i < 2; i++) begin
			runOne(specialWord(6'd0), int'($urandom_range(5, 0)), 1'b0, 5'd0, '0);
			runOne(specialWord(6'd7), int'($urandom_range(5, 0)), 1'b0, 5'd0, '0);
		end
		closeTest();
	endtask

	task automatic latencyRun();
		openTest("latency");
		for (int i = 0; i < 4; i++) begin
			runOne(randomWord(6'd8 + 6'($urandom_range(7, 0))), 0, 1'b0, 5'd0, '0);
		end
		closeTest();
	endtask

	// second word waits while the first bundle is held unacknowledged
	task automatic backPressure();
		logic [31:0] wordA;
		logic [31:0] wordB;
		logic [31:0] pcA;
		logic [31:0] pcB;
		openTest("backPressure");
		wordA = specialWord(6'h24);
		wordB = randomWord(6'd35);
		pcA = {30'($urandom_range(32'h3fff_ffff, 0)), 2'b00};
		pcB = pcA + 32'd4;
		pushExpected(wordA, pcA);
		pushExpected(wordB, pcB);
		fork
			begin
				sendInstr(wordA, pcA, 1'b0, 5'd0, '0);
				sendInstr(wordB, pcB, 1'b0, 5'd0, '0);
			end
			begin
				answerOp(12);
				answerOp(1);
			end
		join
		closeTest();
	endtask

	task automatic writeFirst();
		logic [31:0] word;
		logic [4:0] target;
		openTest("writeFirst");
		target = 5'($urandom_range(31, 1));
		word = specialWord(6'h25);
		word[25:21] = target;
		runOne(word, 2, 1'b1, target, $urandom());
		// sllv reads rt on port 1
		target = 5'($urandom_range(31, 1));
		word = specialWord(6'd4);
		word[20:16] = target;
		runOne(word, 0, 1'b1, target, $urandom());
		closeTest();
	endtask

	initial begin
		repeat (WatchdogCycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, the DUT stopped responding", WatchdogCycles);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		void'($urandom(Seed));
		reset = 1'b1;
		instrReq = 1'b0;
		instr = '0;
		pc = '0;
		wbEnable = 1'b0;
		wbAddr = '0;
		wbData = '0;
		opAck = 1'b0;
		foreach (shadow[r]) begin
			shadow[r] = '0;
		end
		repeat (ResetCycles) @(posedge clk);
		#1;
		reset = 1'b0;
		writebackRead();
		categoryRules();
		shiftSwap();
		latencyRun();
		backPressure();
		writeFirst();
		repeat (4) @(posedge clk);
		if (opIndex != expCount) begin
			reportProtocol("not every accepted instruction produced an operand bundle");
		end
		$display("%0d tests run, %0d failed, %0d errors", testCount, failedTests, errorCount);
		if (errorCount == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: rtl/mipsDecodeStage.sv
`timescale 1ns/1ps

module mipsDecodeStage #(
	parameter int RegCount = 32
) (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             instrReq,
	input  logic [mipsPkg::DataWidth-1:0]    instr,
	input  logic [mipsPkg::DataWidth-1:0]    pc,
	input  logic                             wbEnable,
	input  logic [mipsPkg::RegAddrWidth-1:0] wbAddr,
	input  logic [mipsPkg::DataWidth-1:0]    wbData,
	input  logic                             opAck,
	output logic                             instrAck,
	output logic                             opReq,
	output logic [mipsPkg::DataWidth-1:0]    port1Data,
	output logic [mipsPkg::DataWidth-1:0]    port2Data,
	output logic [mipsPkg::RegAddrWidth-1:0] writeAddr,
	output mipsPkg::writeDataSrc_e           writeDataSrc,
	output logic                             writeEnable,
	output mipsPkg::category_e               category,
	output logic [mipsPkg::ImmWidth-1:0]     imm,
	output logic [mipsPkg::ShamtWidth-1:0]   shamt,
	output logic [mipsPkg::DataWidth-1:0]    pcOut
);

	import mipsPkg::*;

	logic [DataWidth-1:0] instrWord;
	logic [DataWidth-1:0] instrPc;
	logic start;
	logic idle;

	category_e decodedCategory;
	port1Src_e port1Src;
	port2Src_e port2Src;
	writeAddrSrc_e writeAddrSrc;
	writeDataSrc_e ctlWriteDataSrc;
	logic ctlWriteEnable;

	logic [RegAddrWidth-1:0] rs;
	logic [RegAddrWidth-1:0] rt;
	logic [RegAddrWidth-1:0] rd;
	logic [RegAddrWidth-1:0] readAddr1;
	logic [RegAddrWidth-1:0] readAddr2;
	logic [RegAddrWidth-1:0] selWriteAddr;

	logic stageValid;
	logic [DataWidth-1:0] stagePort1Data;
	logic [DataWidth-1:0] stagePort2Data;
	logic [RegAddrWidth-1:0] stageWriteAddr;
	writeDataSrc_e stageWriteDataSrc;
	logic stageWriteEnable;
	category_e stageCategory;
	logic [ImmWidth-1:0] stageImm;
	logic [ShamtWidth-1:0] stageShamt;
	logic [DataWidth-1:0] stagePc;

	instrReceiver instrReceiver_inst (
		.clk(clk),
		.reset(reset),
		.instrReq(instrReq),
		.instr(instr),
		.pc(pc),
		.idle(idle),
		.instrAck(instrAck),
		.instrWord(instrWord),
		.instrPc(instrPc),
		.start(start)
	);

	categoryDecoder categoryDecoder_inst (
		.instrWord(instrWord),
		.category(decodedCategory)
	);

	regControlGenerate regControlGenerate_inst (
		.category(decodedCategory),
		.port1Src(port1Src),
		.port2Src(port2Src),
		.writeAddrSrc(writeAddrSrc),
		.writeDataSrc(ctlWriteDataSrc),
		.writeEnable(ctlWriteEnable)
	);

	assign rs = instrWord[25:21];
	assign rt = instrWord[20:16];
	assign rd = instrWord[15:11];

	// turn the control fields into register numbers
	assign readAddr1 = (port1Src == src1Rt) ? rt : rs;
	assign readAddr2 = (port2Src == src2Rs) ? rs : rt;

	always_comb begin
		case (writeAddrSrc)
			waRd: selWriteAddr = rd;
			waR31: selWriteAddr = RegAddrWidth'(31);
			default: selWriteAddr = rt;
		endcase
	end

	// read data lands at the same edge as the valid stage below
	registerFile #(
		.RegCount(RegCount)
	) registerFile_inst (
		.clk(clk),
		.reset(reset),
		.readAddr1(readAddr1),
		.readAddr2(readAddr2),
		.wbEnable(wbEnable),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.readData1(stagePort1Data),
		.readData2(stagePort2Data)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			stageValid <= 1'b0;
		end else begin
			stageValid <= start;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			stageWriteAddr <= selWriteAddr;
			stageWriteDataSrc <= ctlWriteDataSrc;
			stageWriteEnable <= ctlWriteEnable;
			stageCategory <= decodedCategory;
			stageImm <= instrWord[15:0];
			stageShamt <= instrWord[10:6];
			stagePc <= instrPc;
		end
	end

	operandSender operandSender_inst (
		.clk(clk),
		.reset(reset),
		.start(start),
		.load(stageValid),
		.stagePort1Data(stagePort1Data),
		.stagePort2Data(stagePort2Data),
		.stageWriteAddr(stageWriteAddr),
		.stageWriteDataSrc(stageWriteDataSrc),
		.stageWriteEnable(stageWriteEnable),
		.stageCategory(stageCategory),
		.stageImm(stageImm),
		.stageShamt(stageShamt),
		.stagePc(stagePc),
		.opAck(opAck),
		.port1Data(port1Data),
		.port2Data(port2Data),
		.writeAddr(writeAddr),
		.writeDataSrc(writeDataSrc),
		.writeEnable(writeEnable),
		.category(category),
		.imm(imm),
		.shamt(shamt),
		.pcOut(pcOut),
		.opReq(opReq),
		.idle(idle)
	);

	// an accepted word always reaches opReq two edges after acceptance
	fixedLatency: assert property (@(posedge clk) disable iff (reset)
		$rose(instrAck) |-> ##2 $rose(opReq));

endmodule

// File: rtl/operandSender.sv
`timescale 1ns/1ps

module operandSender (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             start,
	input  logic                             load,
	input  logic [mipsPkg::DataWidth-1:0]    stagePort1Data,
	input  logic [mipsPkg::DataWidth-1:0]    stagePort2Data,
	input  logic [mipsPkg::RegAddrWidth-1:0] stageWriteAddr,
	input  mipsPkg::writeDataSrc_e           stageWriteDataSrc,
	input  logic                             stageWriteEnable,
	input  mipsPkg::category_e               stageCategory,
	input  logic [mipsPkg::ImmWidth-1:0]     stageImm,
	input  logic [mipsPkg::ShamtWidth-1:0]   stageShamt,
	input  logic [mipsPkg::DataWidth-1:0]    stagePc,
	input  logic                             opAck,
	output logic [mipsPkg::DataWidth-1:0]    port1Data,
	output logic [mipsPkg::DataWidth-1:0]    port2Data,
	output logic [mipsPkg::RegAddrWidth-1:0] writeAddr,
	output mipsPkg::writeDataSrc_e           writeDataSrc,
	output logic                             writeEnable,
	output mipsPkg::category_e               category,
	output logic [mipsPkg::ImmWidth-1:0]     imm,
	output logic [mipsPkg::ShamtWidth-1:0]   shamt,
	output logic [mipsPkg::DataWidth-1:0]    pcOut,
	output logic                             opReq,
	output logic                             idle
);

	typedef enum logic [1:0] {txIdle, txBusy, txReq, txRelease} txState_e;

	txState_e state;
	logic capture;

	assign idle = (state == txIdle);
	assign capture = (state == txBusy) && load;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= txIdle;
			opReq <= 1'b0;
		end else begin
			case (state)
				txIdle: if (start) state <= txBusy;
				txBusy: begin
					if (load) begin
						state <= txReq;
						opReq <= 1'b1;
					end
				end
				txReq: begin
					if (opAck) begin
						state <= txRelease;
						opReq <= 1'b0;
					end
				end
				// wait for the sink to finish phase 4
				txRelease: if (!opAck) state <= txIdle;
				default: state <= txIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			port1Data <= stagePort1Data;
			port2Data <= stagePort2Data;
			writeAddr <= stageWriteAddr;
			writeDataSrc <= stageWriteDataSrc;
			writeEnable <= stageWriteEnable;
			category <= stageCategory;
			imm <= stageImm;
			shamt <= stageShamt;
			pcOut <= stagePc;
		end
	end

	reqHeldUntilAck: assert property (@(posedge clk) disable iff (reset)
		(opReq && !opAck) |=> opReq);

endmodule

// File: rtl/registerFile.sv
`timescale 1ns/1ps

module registerFile #(
	parameter int RegCount = 32
) (
	input  logic                             clk,
	input  logic                             reset,
	input  logic [mipsPkg::RegAddrWidth-1:0] readAddr1,
	input  logic [mipsPkg::RegAddrWidth-1:0] readAddr2,
	input  logic                             wbEnable,
	input  logic [mipsPkg::RegAddrWidth-1:0] wbAddr,
	input  logic [mipsPkg::DataWidth-1:0]    wbData,
	output logic [mipsPkg::DataWidth-1:0]    readData1,
	output logic [mipsPkg::DataWidth-1:0]    readData2
);

	import mipsPkg::*;

	logic [DataWidth-1:0] regs [RegCount];
	logic wbValid;

	// r0 and addresses past the implemented set are never written
	assign wbValid = wbEnable && (wbAddr != '0) && (int'(wbAddr) < RegCount);

	function automatic logic [DataWidth-1:0] readPort(input logic [RegAddrWidth-1:0] addr);
		if (addr == '0 || int'(addr) >= RegCount) begin
			return '0;
		end else if (wbValid && addr == wbAddr) begin
			// write-first
			return wbData;
		end else begin
			return regs[addr];
		end
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < RegCount; i++) begin
				regs[i] <= '0;
			end
			readData1 <= '0;
			readData2 <= '0;
		end else begin
			if (wbValid) begin
				regs[wbAddr] <= wbData;
			end
			readData1 <= readPort(readAddr1);
			readData2 <= readPort(readAddr2);
		end
	end

	zeroRead1: assert property (@(posedge clk) disable iff (reset)
		(readAddr1 == '0) |=> (readData1 == '0));
	zeroRead2: assert property (@(posedge clk) disable iff (reset)
		(readAddr2 == '0) |=> (readData2 == '0));

endmodule

// File: rtl/regControlGenerate.sv
`timescale 1ns/1ps

module regControlGenerate (
	input  mipsPkg::category_e      category,
	output mipsPkg::port1Src_e      port1Src,
	output mipsPkg::port2Src_e      port2Src,
	output mipsPkg::writeAddrSrc_e  writeAddrSrc,
	output mipsPkg::writeDataSrc_e  writeDataSrc,
	output logic                    writeEnable
);

	import mipsPkg::*;

	always_comb begin
		// default is an rs/rt read writing an alu result to rt
		port1Src = src1Rs;
		port2Src = src2Rt;
		writeAddrSrc = waRt;
		writeDataSrc = wdAlu;
		writeEnable = 1'b1;

		case (category)
			catShift: begin
				// shifted value comes from rt, amount from rs
				port1Src = src1Rt;
				port2Src = src2Rs;
				writeAddrSrc = waRd;
			end
			catRegister: begin
				writeAddrSrc = waRd;
			end
			catLoad: begin
				writeDataSrc = wdMemory;
			end
			catLink: begin
				writeAddrSrc = waR31;
				writeDataSrc = wdPc;
			end
			catJump, catBranch, catStore, catInvalid: begin
				writeEnable = 1'b0;
			end
			default: begin
				writeEnable = 1'b1;
			end
		endcase

		// a pc writeback only makes sense into the link register
		pcOnlyToR31: assert ((writeDataSrc != wdPc) || (writeAddrSrc == waR31));
	end

endmodule

// File: rtl/categoryDecoder.sv
`timescale 1ns/1ps

module categoryDecoder (
	input  logic [mipsPkg::DataWidth-1:0]  instrWord,
	output mipsPkg::category_e             category
);

	import mipsPkg::*;

	opcode_e opcode;
	funct_e funct;
	logic [RegAddrWidth-1:0] rt;

	assign opcode = opcode_e'(instrWord[31:26]);
	assign funct = funct_e'(instrWord[5:0]);
	assign rt = instrWord[20:16];

	always_comb begin
		case (opcode)
			opSpecial: begin
				case (funct)
					fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav: category = catShift;
					fnJr: category = catJump;
					fnJalr: category = catLink;
					default: category = catRegister;
				endcase
			end
			opRegimm: begin
				// bltzal and bgezal write r31
				if (rt == RegAddrWidth'(16) || rt == RegAddrWidth'(17)) begin
					category = catLink;
				end else begin
					category = catBranch;
				end
			end
			opJ: category = catJump;
			opJal: category = catLink;
			opBeq, opBne, opBlez, opBgtz: category = catBranch;
			opAddi, opAddiu, opSlti, opSltiu,
			opAndi, opOri, opXori, opLui: category = catImmediate;
			opLb, opLh, opLw, opLbu, opLhu: category = catLoad;
			opSb, opSh, opSw: category = catStore;
			default: category = catInvalid;
		endcase
	end

endmodule

// File: rtl/instrReceiver.sv
`timescale 1ns/1ps

module instrReceiver (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           instrReq,
	input  logic [mipsPkg::DataWidth-1:0]  instr,
	input  logic [mipsPkg::DataWidth-1:0]  pc,
	input  logic                           idle,
	output logic                           instrAck,
	output logic [mipsPkg::DataWidth-1:0]  instrWord,
	output logic [mipsPkg::DataWidth-1:0]  instrPc,
	output logic                           start
);

	typedef enum logic {rxWait, rxAcked} rxState_e;

	rxState_e state;
	logic accept;

	// only take a new word when the output side has nothing pending
	assign accept = (state == rxWait) && instrReq && idle;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= rxWait;
			instrAck <= 1'b0;
			start <= 1'b0;
		end else begin
			start <= accept;
			case (state)
				rxWait: begin
					if (accept) begin
						state <= rxAcked;
						instrAck <= 1'b1;
					end
				end
				rxAcked: begin
					// phase 4 once the source has released req
					if (!instrReq) begin
						state <= rxWait;
						instrAck <= 1'b0;
					end
				end
				default: state <= rxWait;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			instrWord <= instr;
			instrPc <= pc;
		end
	end

	ackFollowsReq: assert property (@(posedge clk) disable iff (reset)
		$rose(instrAck) |-> $past(instrReq));

endmodule

// File: rtl/mipsPkg.sv
package mipsPkg;

	localparam int DataWidth = 32;
	localparam int RegAddrWidth = 5;
	localparam int ImmWidth = 16;
	localparam int ShamtWidth = 5;

	// primary opcodes, instr[31:26]
	typedef enum logic [5:0] {
		opSpecial = 6'd0,
		opRegimm = 6'd1,
		opJ = 6'd2,
		opJal = 6'd3,
		opBeq = 6'd4,
		opBne = 6'd5,
		opBlez = 6'd6,
		opBgtz = 6'd7,
		opAddi = 6'd8,
		opAddiu = 6'd9,
		opSlti = 6'd10,
		opSltiu = 6'd11,
		opAndi = 6'd12,
		opOri = 6'd13,
		opXori = 6'd14,
		opLui = 6'd15,
		opLb = 6'd32,
		opLh = 6'd33,
		opLw = 6'd35,
		opLbu = 6'd36,
		opLhu = 6'd37,
		opSb = 6'd40,
		opSh = 6'd41,
		opSw = 6'd43
	} opcode_e;

	// special functions the decoder tells apart, instr[5:0]
	typedef enum logic [5:0] {
		fnSll = 6'd0,
		fnSrl = 6'd2,
		fnSra = 6'd3,
		fnSllv = 6'd4,
		fnSrlv = 6'd6,
		fnSrav = 6'd7,
		fnJr = 6'd8,
		fnJalr = 6'd9
	} funct_e;

	// nine categories need four bits
	typedef enum logic [3:0] {
		catRegister,
		catShift,
		catLoad,
		catStore,
		catBranch,
		catJump,
		catLink,
		catImmediate,
		catInvalid
	} category_e;

	typedef enum logic {src1Rs, src1Rt} port1Src_e;
	typedef enum logic {src2Rt, src2Rs} port2Src_e;
	typedef enum logic [1:0] {waRt, waRd, waR31} writeAddrSrc_e;
	typedef enum logic [1:0] {wdAlu, wdMemory, wdPc} writeDataSrc_e;

endpackage
